/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = vgaDisplayTb
FILELIST  = all.f
OBJDIR    = obj_dir
PASS_MSG  = === PASS ===

.PHONY: all compile run clean

all: run

# Build the simulation executable from the file list
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# Fails unless the pass line shows up in the simulation output
run: compile
	@out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* all.f */
common/vgaTimingPkg.sv
common/frameBufferPkg.sv
vga/vgaTiming.sv
vga/pixelFetch.sv
vga/pixelShaper.sv
hdl/frameBuffer.sv
hdl/vgaDisplay.sv
sim/vgaDisplayTb.sv

/* common/frameBufferPkg.sv */
// Frame buffer geometry, host write request and the fetch record handed to the pixel shaper
package frameBufferPkg;

	localparam int FbWidth     = 160;
	localparam int FbHeight    = 120;
	localparam int FbPages     = FbHeight / 8;	// Eight lines per byte
	localparam int FbBytes     = FbPages * FbWidth;	// 2400
	localparam int FbAddrWidth = 12;

	localparam int ColWidth   = 8;	// Column 0..159
	localparam int RowWidth   = 7;	// Row 0..119
	localparam int ScaleShift = 2;	// Each buffer pixel covers 4x4 screen pixels

	typedef struct packed {
		logic                   strobe;
		logic [FbAddrWidth-1:0] addr;
		logic [7:0]             data;
	} fbWrite_t;

	typedef struct packed {
		logic [2:0]            bitIdx;	// Line within the page
		logic                  visible;
		vgaTimingPkg::timing_t timing;
	} fetch_t;

	localparam fetch_t FetchIdle = '{
		bitIdx:  3'd0,
		visible: 1'b0,
		timing:  vgaTimingPkg::TimingIdle
	};

endpackage

/* common/vgaTimingPkg.sv */
// VGA 640x480 at 60 Hz timing constants, state encoding and the timing record shared by the display stages
package vgaTimingPkg;

	// Horizontal timing in pixel clocks
	localparam int HActive = 640;
	localparam int HFront  = 16;
	localparam int HSync   = 96;
	localparam int HBack   = 48;
	localparam int HTotal  = HActive + HFront + HSync + HBack;	// 800

	// Vertical timing in lines
	localparam int VActive = 480;
	localparam int VFront  = 10;
	localparam int VSync   = 2;
	localparam int VBack   = 33;
	localparam int VTotal  = VActive + VFront + VSync + VBack;	// 525

	localparam int HCountWidth = 10;	// Max 799
	localparam int VCountWidth = 10;	// Max 524

	// Counter position to visible output, in clocks
	localparam int PipeLatency = 3;

	typedef enum logic [1:0] {
		Active = 2'd0,
		Front  = 2'd1,
		Sync   = 2'd2,
		Back   = 2'd3
	} timingState_e;

	typedef struct packed {
		logic hActive;
		logic vActive;
		logic hSync;	// Active low
		logic vSync;	// Active low
		logic lineEnd;	// Last clock of a line
		logic frameEnd;	// Last clock of a frame
	} timing_t;

	// Blanked, syncs released
	localparam timing_t TimingIdle = '{
		hActive:  1'b0,
		vActive:  1'b0,
		hSync:    1'b1,
		vSync:    1'b1,
		lineEnd:  1'b0,
		frameEnd: 1'b0
	};

endpackage

/* hdl/frameBuffer.sv */
// 2400-byte display memory, strobed host write port and one-cycle registered display read port
`timescale 1ns/1ps

module frameBuffer (
	input  logic                                    Clock,
	input  frameBufferPkg::fbWrite_t                write_i,
	input  logic [frameBufferPkg::FbAddrWidth-1:0] readAddr_i,
	output logic [7:0]                              readData_o
);

	logic [7:0] mem [frameBufferPkg::FbBytes];

	logic writeHit;
	logic readHit;

	// Addresses past the last page are dropped
	assign writeHit = write_i.strobe && (write_i.addr < frameBufferPkg::FbBytes);
	assign readHit  = (readAddr_i < frameBufferPkg::FbBytes);

	always_ff @(posedge Clock) begin
		if (writeHit)
			mem[write_i.addr] <= write_i.data;
	end

	// Blanking rows can point past the end
	always_ff @(posedge Clock) begin
		if (readHit)
			readData_o <= mem[readAddr_i];
		else
			readData_o <= 8'h00;
	end

endmodule

/* hdl/vgaDisplay.sv */
// Top level of the VGA display, host writes the frame buffer and the pipeline scans it to the monitor
`timescale 1ns/1ps

module vgaDisplay (
	input  logic                     Clock,	// 25 MHz pixel clock
	input  logic                     Reset,
	input  frameBufferPkg::fbWrite_t write_i,
	output logic                     Red_o,
	output logic                     Green_o,
	output logic                     Blue_o,
	output logic                     HSync_o,
	output logic                     VSync_o
);

	vgaTimingPkg::timing_t                   timing;
	frameBufferPkg::fetch_t                  fetch;
	logic [frameBufferPkg::FbAddrWidth-1:0] readAddr;
	logic [7:0]                              readData;

	vgaTiming i_vgaTiming (
		.Clock    (Clock),
		.Reset    (Reset),
		.timing_o (timing)
	);

	pixelFetch i_pixelFetch (
		.Clock      (Clock),
		.Reset      (Reset),
		.timing_i   (timing),
		.readAddr_o (readAddr),
		.fetch_o    (fetch)
	);

	frameBuffer i_frameBuffer (
		.Clock      (Clock),
		.write_i    (write_i),
		.readAddr_i (readAddr),
		.readData_o (readData)
	);

	pixelShaper i_pixelShaper (
		.Clock      (Clock),
		.Reset      (Reset),
		.fetch_i    (fetch),
		.readData_i (readData),
		.Red_o      (Red_o),
		.Green_o    (Green_o),
		.Blue_o     (Blue_o),
		.HSync_o    (HSync_o),
		.VSync_o    (VSync_o)
	);

endmodule

/* sim/vgaDisplayTb.sv */
// Testbench for the VGA display that fills the frame buffer from an LFSR and checks two frames of output
`timescale 1ns/1ps

module vgaDisplayTb;

	localparam int ResetCycles = 10;
	// Reset, the 2400-byte fill and two 420000-clock frames come to about 842400 clocks
	localparam int TimeoutCycles = 860000;

	typedef struct packed {
		logic red;
		logic green;
		logic blue;
		logic hSync;
		logic vSync;
	} pins_t;

	localparam pins_t PinsIdle = '{
		red:   1'b0,
		green: 1'b0,
		blue:  1'b0,
		hSync: 1'b1,
		vSync: 1'b1
	};

	logic                     Clock;
	logic                     Reset;
	frameBufferPkg::fbWrite_t hostWrite;
	logic                     red;
	logic                     green;
	logic                     blue;
	logic                     hSync;
	logic                     vSync;

	logic [7:0] model [frameBufferPkg::FbBytes];	// Bytes as the host wrote them
	int         cycleCount;
	int         posH;	// Screen position now on the pins
	int         posV;
	logic       checksDone;

	vgaDisplay i_vgaDisplay (
		.Clock   (Clock),
		.Reset   (Reset),
		.write_i (hostWrite),
		.Red_o   (red),
		.Green_o (green),
		.Blue_o  (blue),
		.HSync_o (hSync),
		.VSync_o (vSync)
	);

	// 16-bit Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsrNext(input logic [15:0] state);
		logic feedback;
		feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
		return {state[14:0], feedback};
	endfunction

	// Expected pin levels for screen position (h, v) with the image taken from the model bytes
	function automatic pins_t refPins(input int h, input int v);
		pins_t pins;
		int    hSyncStart;
		int    vSyncStart;
		int    column;
		int    row;
		int    addr;
		logic  lit;
		hSyncStart = vgaTimingPkg::HActive + vgaTimingPkg::HFront;
		vSyncStart = vgaTimingPkg::VActive + vgaTimingPkg::VFront;
		column     = h >> frameBufferPkg::ScaleShift;
		row        = v >> frameBufferPkg::ScaleShift;
		lit        = 1'b0;
		if (h < vgaTimingPkg::HActive && v < vgaTimingPkg::VActive) begin
			addr = (row / 8) * frameBufferPkg::FbWidth + column;	// Page organized
			lit  = model[addr][row % 8];
		end
		pins.red   = lit;
		pins.green = lit;
		pins.blue  = lit;
		pins.hSync = !(h >= hSyncStart && h < hSyncStart + vgaTimingPkg::HSync);
		pins.vSync = !(v >= vSyncStart && v < vSyncStart + vgaTimingPkg::VSync);
		return pins;
	endfunction

	task automatic checkValue(input string testName, input logic [7:0] expected,
		input logic [7:0] actual);
		if (actual !== expected) begin
			$display("Mismatch in %s at h=%0d v=%0d: expected %h, actual %h",
				testName, posH, posV, expected, actual);
			$display("=== FAIL ===");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	initial begin
		Clock = 1'b0;
		forever #10 Clock = ~Clock;	// Period of 20 ns
	end

	// Reset, buffer fill and end of run
	initial begin : stimulus
		logic [15:0] lfsr;
		logic [7:0]  data;
		int          addr;
		int          b;

		checksDone = 1'b0;
		Reset      = 1'b0;
		hostWrite  = '0;
		lfsr       = 16'd94;
		data       = 8'h00;

		repeat (ResetCycles) @(posedge Clock);
		Reset <= 1'b1;

		for (addr = 0; addr < frameBufferPkg::FbBytes; addr++) begin
			for (b = 0; b < 8; b++) begin
				lfsr = lfsrNext(lfsr);	// One step per data bit
				data = {data[6:0], lfsr[0]};
			end
			model[addr] = data;
			@(posedge Clock);
			hostWrite <= '{strobe: 1'b1, addr: frameBufferPkg::FbAddrWidth'(addr), data: data};
		end

		// Out of range writes that must not touch the image
		@(posedge Clock);
		hostWrite <= '{
			strobe: 1'b1,
			addr:   frameBufferPkg::FbAddrWidth'(frameBufferPkg::FbBytes),
			data:   8'hFF
		};
		@(posedge Clock);
		hostWrite <= '{strobe: 1'b1, addr: '1, data: 8'hFF};
		@(posedge Clock);
		hostWrite.strobe <= 1'b0;

		wait (checksDone);
		$display("=== PASS ===");
		$finish;
	end

	// Follows the raster PipeLatency clocks behind the DUT counters
	initial begin : compareOutputs
		pins_t expected;
		pins_t actual;
		int    settleCycles;
		int    frame;
		logic  inActive;

		posH         = 0;
		posV         = 0;
		frame        = 0;
		settleCycles = 0;

		@(posedge Clock);
		@(negedge Clock);
		while (Reset !== 1'b1) begin
			actual = {red, green, blue, hSync, vSync};
			checkValue("reset idle", 8'(PinsIdle), 8'(actual));
			@(negedge Clock);
		end

		// First pass here is the clock where the counters hold (0,0)
		while (frame < 2) begin
			actual = {red, green, blue, hSync, vSync};
			if (settleCycles < vgaTimingPkg::PipeLatency) begin
				checkValue("startup idle", 8'(PinsIdle), 8'(actual));
				settleCycles++;
			end else begin
				expected = refPins(posH, posV);
				inActive = (posH < vgaTimingPkg::HActive) && (posV < vgaTimingPkg::VActive);
				checkValue("hsync", 8'(expected.hSync), 8'(actual.hSync));
				checkValue("vsync", 8'(expected.vSync), 8'(actual.vSync));
				if (!inActive)
					checkValue("blank rgb", 8'({expected.red, expected.green, expected.blue}),
						8'({actual.red, actual.green, actual.blue}));
				else if (frame == 1)	// Image is settled once the fill is over
					checkValue("image", 8'({expected.red, expected.green, expected.blue}),
						8'({actual.red, actual.green, actual.blue}));

				if (posH == vgaTimingPkg::HTotal - 1) begin
					posH = 0;
					if (posV == vgaTimingPkg::VTotal - 1) begin
						posV = 0;
						frame++;
					end else begin
						posV++;
					end
				end else begin
					posH++;
				end
			end
			@(negedge Clock);
		end
		checksDone = 1'b1;
	end

	// Watchdog
	initial begin
		cycleCount = 0;
		forever begin
			@(posedge Clock);
			cycleCount++;
			if (cycleCount >= TimeoutCycles) begin
				$display("Timeout: the two frames were not checked within %0d clock cycles",
					TimeoutCycles);
				$display("=== FAIL ===");
				$fatal(1, "Simulation timed out");
			end
		end
	end

endmodule

/* vga/pixelFetch.sv */
// Second display stage, scales the raster down to 160x120 and addresses the page-organized buffer
`timescale 1ns/1ps

module pixelFetch (
	input  logic                                    Clock,
	input  logic                                    Reset,
	input  vgaTimingPkg::timing_t                   timing_i,
	output logic [frameBufferPkg::FbAddrWidth-1:0] readAddr_o,
	output frameBufferPkg::fetch_t                  fetch_o
);

	logic [frameBufferPkg::ScaleShift-1:0] hDiv;
	logic [frameBufferPkg::ScaleShift-1:0] vDiv;
	logic [frameBufferPkg::ColWidth-1:0]   column;	// Max 159 in the active area
	logic [frameBufferPkg::RowWidth-1:0]   row;	// Max 119 in the active area

	logic       activeArea;
	logic [3:0] pageNum;

	assign activeArea = timing_i.hActive && timing_i.vActive;
	assign pageNum    = row[frameBufferPkg::RowWidth-1:3];

	// Scaler state always points at the position now on timing_i
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			hDiv   <= '0;
			vDiv   <= '0;
			column <= '0;
			row    <= '0;
		end else begin
			if (activeArea) begin
				if (&hDiv)
					column <= column + 1'b1;	// Every fourth active clock
				hDiv <= hDiv + 1'b1;
			end else begin
				hDiv   <= '0;
				column <= '0;
			end

			if (timing_i.lineEnd) begin
				if (timing_i.frameEnd || !timing_i.vActive) begin
					vDiv <= '0;
					row  <= '0;
				end else begin
					if (&vDiv)
						row <= row + 1'b1;	// Every fourth active line
					vDiv <= vDiv + 1'b1;
				end
			end
		end
	end

	// Page times row stride plus column
	assign readAddr_o = frameBufferPkg::FbAddrWidth'(pageNum * frameBufferPkg::FbWidth + column);

	// Lines up with the registered read byte
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			fetch_o <= frameBufferPkg::FetchIdle;
		end else begin
			fetch_o.bitIdx  <= row[2:0];	// Line within the page
			fetch_o.visible <= activeArea;
			fetch_o.timing  <= timing_i;
		end
	end

endmodule

/* vga/pixelShaper.sv */
// Last display stage, selects the pixel bit and registers the colour and sync pins
`timescale 1ns/1ps

module pixelShaper (
	input  logic                   Clock,
	input  logic                   Reset,
	input  frameBufferPkg::fetch_t fetch_i,
	input  logic [7:0]             readData_i,
	output logic                   Red_o,
	output logic                   Green_o,
	output logic                   Blue_o,
	output logic                   HSync_o,
	output logic                   VSync_o
);

	logic pixelOn;

	assign pixelOn = fetch_i.visible && readData_i[fetch_i.bitIdx];

	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			Red_o   <= 1'b0;
			Green_o <= 1'b0;
			Blue_o  <= 1'b0;
			HSync_o <= 1'b1;
			VSync_o <= 1'b1;
		end else begin
			// Monochrome, lit pixels are white
			Red_o   <= pixelOn;
			Green_o <= pixelOn;
			Blue_o  <= pixelOn;
			HSync_o <= fetch_i.timing.hSync;
			VSync_o <= fetch_i.timing.vSync;
		end
	end

endmodule

/* vga/vgaTiming.sv */
// First display stage, scans the 800x525 raster and registers the timing record for each position
`timescale 1ns/1ps

module vgaTiming (
	input  logic                  Clock,
	input  logic                  Reset,
	output vgaTimingPkg::timing_t timing_o
);

	logic [vgaTimingPkg::HCountWidth-1:0] hCount;
	logic [vgaTimingPkg::VCountWidth-1:0] vCount;

	vgaTimingPkg::timingState_e hState;
	vgaTimingPkg::timingState_e vState;

	logic lineEnd;
	logic frameEnd;

	assign lineEnd  = (hCount == vgaTimingPkg::HTotal - 1);
	assign frameEnd = lineEnd && (vCount == vgaTimingPkg::VTotal - 1);

	// Raster counters
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			hCount <= '0;
			vCount <= '0;
		end else if (lineEnd) begin
			hCount <= '0;
			if (frameEnd)
				vCount <= '0;
			else
				vCount <= vCount + 1'b1;
		end else begin
			hCount <= hCount + 1'b1;
		end
	end

	// Horizontal FSM, state always matches the region of hCount
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			hState <= vgaTimingPkg::Active;
		end else begin
			case (hState)
				vgaTimingPkg::Active: begin
					if (hCount == vgaTimingPkg::HActive - 1)
						hState <= vgaTimingPkg::Front;
				end
				vgaTimingPkg::Front: begin
					if (hCount == vgaTimingPkg::HActive + vgaTimingPkg::HFront - 1)
						hState <= vgaTimingPkg::Sync;
				end
				vgaTimingPkg::Sync: begin
					if (hCount == vgaTimingPkg::HTotal - vgaTimingPkg::HBack - 1)
						hState <= vgaTimingPkg::Back;
				end
				vgaTimingPkg::Back: begin
					if (lineEnd)
						hState <= vgaTimingPkg::Active;
				end
				default: hState <= vgaTimingPkg::Active;
			endcase
		end
	end

	// Vertical FSM, only steps on the last clock of a line
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			vState <= vgaTimingPkg::Active;
		end else if (lineEnd) begin
			case (vState)
				vgaTimingPkg::Active: begin
					if (vCount == vgaTimingPkg::VActive - 1)
						vState <= vgaTimingPkg::Front;
				end
				vgaTimingPkg::Front: begin
					if (vCount == vgaTimingPkg::VActive + vgaTimingPkg::VFront - 1)
						vState <= vgaTimingPkg::Sync;
				end
				vgaTimingPkg::Sync: begin
					if (vCount == vgaTimingPkg::VTotal - vgaTimingPkg::VBack - 1)
						vState <= vgaTimingPkg::Back;
				end
				vgaTimingPkg::Back: begin
					if (frameEnd)
						vState <= vgaTimingPkg::Active;
				end
				default: vState <= vgaTimingPkg::Active;
			endcase
		end
	end

	// Timing record, one clock behind the counters
	always_ff @(posedge Clock or negedge Reset) begin
		if (!Reset) begin
			timing_o <= vgaTimingPkg::TimingIdle;
		end else begin
			timing_o.hActive  <= (hState == vgaTimingPkg::Active);
			timing_o.vActive  <= (vState == vgaTimingPkg::Active);
			timing_o.hSync    <= (hState != vgaTimingPkg::Sync);
			timing_o.vSync    <= (vState != vgaTimingPkg::Sync);
			timing_o.lineEnd  <= lineEnd;
			timing_o.frameEnd <= frameEnd;
		end
	end

endmodule
